// File: src/gift_pkg.sv
package gift_pkg;

    localparam int MAX_DIGITS      = 10;
    localparam int MAX_RANGES      = 16;
    localparam int PERIODS_PER_LEN = 3;

    typedef logic [39:0] bcd_t;        // 10 packed BCD digits
    typedef logic [3:0]  digit_t;
    typedef logic [63:0] bin_t;
    typedef logic [3:0]  len_t;        // digit count 1..10
    typedef logic [3:0]  range_idx_t;
    typedef logic [4:0]  range_cnt_t;  // 0..16

    // ##################################################
    // period table entry: {valid, subtract, period[3:0]}
    // ##################################################
    typedef logic [5:0] period_ent_t;

    localparam int          PE_VALID_BIT = 5;
    localparam int          PE_SUB_BIT   = 4;
    localparam period_ent_t PE_NONE      = 6'h00;
    localparam period_ent_t PE_ADD       = 6'h20;
    localparam period_ent_t PE_SUB       = 6'h30;

    // inclusion-exclusion over the maximal proper divisors of each length
    localparam period_ent_t PERIOD_TABLE [0:MAX_DIGITS][0:PERIODS_PER_LEN-1] = '{
        '{PE_NONE,        PE_NONE,        PE_NONE},
        '{PE_NONE,        PE_NONE,        PE_NONE},         // single digit never repeats
        '{PE_ADD | 6'd1,  PE_NONE,        PE_NONE},
        '{PE_ADD | 6'd1,  PE_NONE,        PE_NONE},
        '{PE_ADD | 6'd2,  PE_NONE,        PE_NONE},         // period 1 is a subset of 2
        '{PE_ADD | 6'd1,  PE_NONE,        PE_NONE},
        '{PE_ADD | 6'd3,  PE_ADD | 6'd2,  PE_SUB | 6'd1},
        '{PE_ADD | 6'd1,  PE_NONE,        PE_NONE},
        '{PE_ADD | 6'd4,  PE_NONE,        PE_NONE},
        '{PE_ADD | 6'd3,  PE_NONE,        PE_NONE},
        '{PE_ADD | 6'd5,  PE_ADD | 6'd2,  PE_SUB | 6'd1}
    };

    // position of the highest nonzero digit, 1 for zero
    function automatic len_t bcd_len(bcd_t value);
        len_t len;
        len = 4'd1;
        for (int i = 1; i < MAX_DIGITS; i++) begin
            if (value[4*i +: 4] != 4'd0) begin
                len = len_t'(i + 1);
            end
        end
        return len;
    endfunction

endpackage

// File: src/wb_pkg.sv
package wb_pkg;

    typedef logic [5:0]  wb_adr_t;     // word address
    typedef logic [63:0] wb_dat_t;

    // ##################################################
    // register map
    // ##################################################
    localparam wb_adr_t ADR_CTRL    = 6'h00;   // bit 0 starts a run
    localparam wb_adr_t ADR_STATUS  = 6'h01;   // bit 0 busy, bit 1 done
    localparam wb_adr_t ADR_COUNT   = 6'h02;
    localparam wb_adr_t ADR_RESULT  = 6'h03;

    // range table, 16 words each
    localparam wb_adr_t ADR_LO_BASE = 6'h10;   // lower bounds 0x10..0x1f
    localparam wb_adr_t ADR_HI_BASE = 6'h20;   // upper bounds 0x20..0x2f

endpackage

// File: src/range_table_if.sv
`timescale 1ns/10ps

interface range_table_if
    import gift_pkg::*;
();
    range_idx_t idx;
    bcd_t       lo;
    bcd_t       hi;
    range_cnt_t count;
    logic       start;   // one-cycle run request
    logic       busy;
    bin_t       total;
    logic       finish;  // total is final

    modport regs (input idx, busy, total, finish, output lo, hi, count, start);
    modport seq  (output idx, busy, total, finish, input lo, hi, count, start);

endinterface

// File: src/period_job_if.sv
`timescale 1ns/10ps

interface period_job_if
    import gift_pkg::*;
();
    // request side, held stable until ack
    logic req;
    bcd_t lo;
    bcd_t hi;
    len_t period;

    // response side
    logic ack;        // single-cycle pulse
    bin_t block_sum;

    modport seq  (output req, lo, hi, period, input ack, block_sum);
    modport unit (input req, lo, hi, period, output ack, block_sum);

endinterface

// File: src/wb_range_regs.sv
`timescale 1ns/10ps

module wb_range_regs
    import gift_pkg::*;
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  wb_adr_t     adr,
    input  wb_dat_t     dat_w,
    output wb_dat_t     dat_r,
    output logic        ack,
    range_table_if.regs tbl
);

    bcd_t       lo_tbl [MAX_RANGES];
    bcd_t       hi_tbl [MAX_RANGES];
    range_cnt_t count;
    logic       done;
    bin_t       result;
    logic       start_q;

    logic       access;
    logic       wr_ok;
    logic       lo_sel;
    logic       hi_sel;
    range_idx_t slot;
    wb_dat_t    rd_data;

    assign access = cyc & stb & ~ack;      // ack gap forces one idle cycle
    assign wr_ok  = access & we & ~tbl.busy;
    assign lo_sel = (adr[5:4] == ADR_LO_BASE[5:4]);
    assign hi_sel = (adr[5:4] == ADR_HI_BASE[5:4]);
    assign slot   = range_idx_t'(adr[3:0]);

    assign tbl.lo    = lo_tbl[tbl.idx];
    assign tbl.hi    = hi_tbl[tbl.idx];
    assign tbl.count = count;
    assign tbl.start = start_q;

    // ##################################################
    // range table
    // ##################################################
    always_ff @(posedge clk) begin
        if (wr_ok && lo_sel) begin
            lo_tbl[slot] <= bcd_t'(dat_w);
        end
        if (wr_ok && hi_sel) begin
            hi_tbl[slot] <= bcd_t'(dat_w);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count   <= '0;
            done    <= 1'b0;
            result  <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= wr_ok && (adr == ADR_CTRL) && dat_w[0];
            if (wr_ok && (adr == ADR_COUNT)) begin
                // saturate at table size
                count <= (dat_w > MAX_RANGES) ? range_cnt_t'(MAX_RANGES) : range_cnt_t'(dat_w);
            end
            if (start_q) begin
                done <= 1'b0;
            end else if (tbl.finish) begin
                done   <= 1'b1;
                result <= tbl.total;
            end
        end
    end

    // ##################################################
    // read path and ack
    // ##################################################
    always_comb begin
        rd_data = '0;
        if (lo_sel) begin
            rd_data = wb_dat_t'(lo_tbl[slot]);
        end else if (hi_sel) begin
            rd_data = wb_dat_t'(hi_tbl[slot]);
        end else begin
            case (adr)
                ADR_STATUS: rd_data = wb_dat_t'({done, tbl.busy});
                ADR_COUNT:  rd_data = wb_dat_t'(count);
                ADR_RESULT: rd_data = result;
                default:    rd_data = '0;   // ctrl is write only
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack   <= 1'b0;
            dat_r <= '0;
        end else begin
            ack <= access;
            if (access && !we) begin
                dat_r <= rd_data;
            end
        end
    end

endmodule

// File: src/range_sequencer.sv
`timescale 1ns/10ps

module range_sequencer
    import gift_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    range_table_if.seq tbl,
    period_job_if.seq  job
);

    typedef enum logic [2:0] {
        idle,
        load,
        split,
        pick_period,
        wait_job,
        next
    } seq_state_t;

    seq_state_t  state;
    range_idx_t  idx;
    bcd_t        cur_lo;
    bcd_t        cur_hi;
    bcd_t        seg_hi;     // top of the same-length segment
    len_t        len;
    logic [1:0]  ent;
    logic        more;       // upper part of a split range still pending
    logic        req;
    bin_t        total;

    len_t        lo_len;
    len_t        hi_len;
    period_ent_t pe;
    logic        last_range;

    function automatic bcd_t all_nines(len_t n);
        bcd_t v;
        v = '0;
        for (int i = 0; i < MAX_DIGITS; i++) begin
            if (i < n) begin
                v[4*i +: 4] = 4'h9;
            end
        end
        return v;
    endfunction

    assign lo_len     = bcd_len(cur_lo);
    assign hi_len     = bcd_len(cur_hi);
    assign pe         = (ent < PERIODS_PER_LEN) ? PERIOD_TABLE[len][ent] : PE_NONE;
    assign last_range = (range_cnt_t'(idx) + 5'd1 >= tbl.count);

    assign tbl.idx    = idx;
    assign tbl.busy   = (state != idle);
    assign tbl.total  = total;
    assign tbl.finish = (state == next) && !more && last_range;   // busy still high here

    // fields only move after ack, so they stay stable while req is up
    assign job.req    = req;
    assign job.lo     = cur_lo;
    assign job.hi     = seg_hi;
    assign job.period = pe[3:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= idle;
            idx    <= '0;
            cur_lo <= '0;
            cur_hi <= '0;
            seg_hi <= '0;
            len    <= '0;
            ent    <= '0;
            more   <= 1'b0;
            req    <= 1'b0;
            total  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (tbl.start) begin
                        idx   <= '0;
                        total <= '0;
                        more  <= 1'b0;
                        state <= (tbl.count == '0) ? next : load;
                    end
                end
                load: begin
                    cur_lo <= tbl.lo;
                    cur_hi <= tbl.hi;
                    state  <= split;
                end
                split: begin
                    ent <= '0;
                    if (cur_lo > cur_hi) begin
                        more  <= 1'b0;   // empty range
                        state <= next;
                    end else begin
                        len    <= lo_len;
                        more   <= (lo_len != hi_len);
                        seg_hi <= (lo_len != hi_len) ? all_nines(lo_len) : cur_hi;
                        state  <= pick_period;
                    end
                end
                pick_period: begin
                    if (pe[PE_VALID_BIT]) begin
                        req   <= 1'b1;
                        state <= wait_job;
                    end else begin
                        state <= next;
                    end
                end
                wait_job: begin
                    if (job.ack) begin
                        req   <= 1'b0;
                        total <= pe[PE_SUB_BIT] ? total - job.block_sum : total + job.block_sum;
                        ent   <= ent + 2'd1;
                        state <= pick_period;
                    end
                end
                next: begin
                    if (more) begin
                        cur_lo <= bcd_t'(1) << {len, 2'b00};   // 10^len
                        state  <= split;
                    end else if (last_range) begin
                        state <= idle;
                    end else begin
                        idx   <= idx + 4'd1;
                        state <= load;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: src/period_sum_unit.sv
`timescale 1ns/10ps

module period_sum_unit
    import gift_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    period_job_if.unit job
);

    typedef enum logic [2:0] {
        idle,
        convert,
        replicate,
        adjust,
        halve,
        product,
        scale,
        respond
    } unit_state_t;

    unit_state_t state;
    bcd_t        lo_r;
    bcd_t        hi_r;
    bcd_t        rep_lo;     // top block of lo repeated k times
    bcd_t        rep_hi;
    len_t        p_r;
    len_t        len_r;
    len_t        k_r;
    len_t        cnt;
    bin_t        a;
    bin_t        b;
    bin_t        pow;        // 10^p
    bin_t        mult;       // 1 + 10^p + ... over k terms
    bin_t        f1;
    bin_t        f2;
    bin_t        prod;
    bin_t        sum_r;

    digit_t      dig_lo;
    digit_t      dig_hi;
    logic [5:0]  dig_shift;
    logic [5:0]  blk_shift;
    bcd_t        blk_lo;
    bcd_t        blk_hi;
    bin_t        span;
    bin_t        pair_sum;

    assign dig_shift = {len_r - 4'd1 - cnt, 2'b00};
    assign dig_lo    = lo_r[dig_shift +: 4];
    assign dig_hi    = hi_r[dig_shift +: 4];
    assign blk_shift = {len_r - p_r, 2'b00};
    assign blk_lo    = lo_r >> blk_shift;
    assign blk_hi    = hi_r >> blk_shift;
    assign span      = b - a + 64'd1;
    assign pair_sum  = a + b;

    assign job.ack       = (state == respond);
    assign job.block_sum = sum_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= idle;
            lo_r   <= '0;
            hi_r   <= '0;
            rep_lo <= '0;
            rep_hi <= '0;
            p_r    <= '0;
            len_r  <= '0;
            k_r    <= '0;
            cnt    <= '0;
            a      <= '0;
            b      <= '0;
            pow    <= '0;
            mult   <= '0;
            f1     <= '0;
            f2     <= '0;
            prod   <= '0;
            sum_r  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (job.req) begin
                        lo_r  <= job.lo;
                        hi_r  <= job.hi;
                        p_r   <= job.period;
                        len_r <= bcd_len(job.lo);
                        k_r   <= bcd_len(job.lo) / job.period;
                        cnt   <= '0;
                        a     <= '0;
                        b     <= '0;
                        pow   <= 64'd1;
                        mult  <= 64'd1;
                        state <= convert;
                    end
                end
                // ##################################################
                // top p digits to binary, x10 as shift-add
                // ##################################################
                convert: begin
                    a   <= (a << 3) + (a << 1) + bin_t'(dig_lo);
                    b   <= (b << 3) + (b << 1) + bin_t'(dig_hi);
                    pow <= (pow << 3) + (pow << 1);
                    if (cnt == p_r - 4'd1) begin
                        cnt    <= 4'd1;
                        rep_lo <= blk_lo;
                        rep_hi <= blk_hi;
                        state  <= replicate;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                replicate: begin
                    if (cnt < k_r) begin
                        rep_lo <= (rep_lo << {p_r, 2'b00}) | blk_lo;
                        rep_hi <= (rep_hi << {p_r, 2'b00}) | blk_hi;
                        mult   <= mult * pow + 64'd1;
                        cnt    <= cnt + 4'd1;
                    end else begin
                        state <= adjust;
                    end
                end
                adjust: begin
                    if (rep_lo < lo_r) begin
                        a <= a + 64'd1;
                    end
                    if (rep_hi > hi_r) begin
                        b <= b - 64'd1;
                    end
                    state <= halve;
                end
                // arithmetic series, exactly one of count and end sum is even
                halve: begin
                    if (b >= a) begin
                        if (!span[0]) begin
                            f1 <= span >> 1;
                            f2 <= pair_sum;
                        end else begin
                            f1 <= pair_sum >> 1;
                            f2 <= span;
                        end
                        state <= product;
                    end else begin
                        sum_r <= '0;   // no block fits
                        state <= respond;
                    end
                end
                product: begin
                    prod  <= f1 * f2;
                    state <= scale;
                end
                scale: begin
                    sum_r <= prod * mult;
                    state <= respond;
                end
                respond: state <= idle;
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: src/gift_shop_top.sv
`timescale 1ns/10ps

module gift_shop_top
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wb_adr_t adr,
    input  wb_dat_t dat_w,
    output wb_dat_t dat_r,
    output logic    ack
);

    range_table_if tbl_if ();
    period_job_if  job_if ();

    wb_range_regs u_regs (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .tbl   (tbl_if.regs)
    );

    range_sequencer u_seq (
        .clk (clk),
        .rst (rst),
        .tbl (tbl_if.seq),
        .job (job_if.seq)
    );

    period_sum_unit u_unit (
        .clk (clk),
        .rst (rst),
        .job (job_if.unit)
    );

endmodule

// File: verif/gift_checker.sv
`timescale 1ns/10ps

module gift_checker
    import gift_pkg::*;
    import wb_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    cyc,
    input logic    stb,
    input logic    we,
    input wb_adr_t adr,
    input wb_dat_t dat_w,
    input wb_dat_t dat_r,
    input logic    ack
);

    longint unsigned lo_tbl [MAX_RANGES];
    longint unsigned hi_tbl [MAX_RANGES];
    int              count;
    bit              running;     // start accepted but done not seen yet
    bit              started;
    bit              rd_pending;  // read accepted with data due one edge later
    bit              ack_due;     // access accepted on the previous edge
    wb_adr_t         rd_adr;
    int              checks = 0;
    int              errors = 0;

    function automatic longint unsigned from_bcd(bcd_t b);
        longint unsigned v;
        v = 0;
        for (int i = MAX_DIGITS - 1; i >= 0; i--) begin
            v = v * 10 + b[4*i +: 4];
        end
        return v;
    endfunction

    // true when the decimal digits are one block repeated two or more times
    function automatic bit is_repeated(longint unsigned n);
        int d [20];
        int len;
        bit same;
        len = 0;
        while (n != 0) begin
            d[len] = int'(n % 10);
            n      = n / 10;
            len++;
        end
        for (int p = 1; p <= len / 2; p++) begin
            if (len % p == 0) begin
                same = 1'b1;
                for (int i = p; i < len; i++) begin
                    if (d[i] != d[i-p]) begin
                        same = 1'b0;
                    end
                end
                if (same) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    function automatic bin_t expected_total();
        bin_t sum;
        sum = '0;
        for (int r = 0; r < count; r++) begin
            for (longint unsigned n = lo_tbl[r]; n <= hi_tbl[r]; n++) begin
                if (is_repeated(n)) begin
                    sum = sum + n;
                end
            end
        end
        return sum;
    endfunction

    task automatic compare_read(input string name, input wb_dat_t exp, input wb_dat_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected 0x%016h, actual 0x%016h", name, exp, act);
        end else begin
            $display("check %0d %s ok: 0x%016h", checks, name, act);
        end
    endtask

    task automatic report_counts();
        $display("%0d checks done, %0d errors", checks, errors);
    endtask

    // ##################################################
    // bus snooping
    // ##################################################
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            count      = 0;
            running    = 1'b0;
            started    = 1'b0;
            rd_pending = 1'b0;
            ack_due    = 1'b0;
            rd_adr     = '0;
        end else begin
            if (ack !== ack_due) begin
                errors++;
                if (ack_due) begin
                    $display("bus ack did not follow the accepted access by one cycle");
                end else begin
                    $display("bus ack was raised without an accepted access one cycle before");
                end
            end
            if (rd_pending) begin
                rd_pending = 1'b0;
                case (rd_adr)
                    ADR_STATUS: begin
                        if (!started) begin
                            compare_read("status", '0, dat_r);   // idle after reset
                        end else if (dat_r[1]) begin
                            running = 1'b0;
                            compare_read("status", 64'h2, dat_r);   // busy drops as done rises
                        end
                    end
                    ADR_COUNT:  compare_read("count", wb_dat_t'(count), dat_r);
                    ADR_RESULT: compare_read("result", expected_total(), dat_r);
                    default: ;
                endcase
            end
            if (cyc && stb && !ack) begin   // same acceptance as the slave
                if (!we) begin
                    rd_pending = 1'b1;
                    rd_adr     = adr;
                end else if (!running) begin
                    if (adr == ADR_COUNT) begin
                        count = (dat_w > MAX_RANGES) ? MAX_RANGES : int'(dat_w);
                    end else if (adr[5:4] == ADR_LO_BASE[5:4]) begin
                        lo_tbl[adr[3:0]] = from_bcd(dat_w[39:0]);
                    end else if (adr[5:4] == ADR_HI_BASE[5:4]) begin
                        hi_tbl[adr[3:0]] = from_bcd(dat_w[39:0]);
                    end else if (adr == ADR_CTRL && dat_w[0]) begin
                        running = 1'b1;
                        started = 1'b1;
                    end
                end
            end
            ack_due = cyc && stb && !ack;
        end
    end

endmodule

// File: verif/tb_gift_shop.sv
`timescale 1ns/10ps

module tb_gift_shop
    import gift_pkg::*;
    import wb_pkg::*;
();

    localparam int              BUS_TIMEOUT  = 20;
    localparam int              POLL_TIMEOUT = 5000;
    localparam longint unsigned MAX_VALUE    = 64'd9999999999;

    logic    clk;
    logic    rst;
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat_w;
    wb_dat_t dat_r;
    logic    ack;

    gift_shop_top uut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    gift_checker chk (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #2 clk = ~clk;

    function automatic bcd_t to_bcd(longint unsigned v);
        bcd_t b;
        b = '0;
        for (int i = 0; i < MAX_DIGITS; i++) begin
            b[4*i +: 4] = digit_t'(v % 10);
            v = v / 10;
        end
        return b;
    endfunction

    function automatic longint unsigned pow10(int e);
        longint unsigned v;
        v = 1;
        for (int i = 0; i < e; i++) begin
            v = v * 10;
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $finish;
    endtask

    // ##################################################
    // bus master
    // ##################################################
    task automatic wb_write(input wb_adr_t a, input wb_dat_t d);
        int n;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        n     = 0;
        @(negedge clk);
        while (!ack) begin
            if (n == BUS_TIMEOUT) begin
                abort_run("timed out waiting for ack on a bus write");
            end
            n++;
            @(negedge clk);
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input wb_adr_t a, output wb_dat_t d);
        int n;
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        n   = 0;
        @(negedge clk);
        while (!ack) begin
            if (n == BUS_TIMEOUT) begin
                abort_run("timed out waiting for ack on a bus read");
            end
            n++;
            @(negedge clk);
        end
        d   = dat_r;   // registered with ack
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic wait_done();
        wb_dat_t st;
        int      n;
        n = 0;
        wb_read(ADR_STATUS, st);
        while (!st[1]) begin
            if (n == POLL_TIMEOUT) begin
                abort_run("timed out polling status for the done bit");
            end
            n++;
            wb_read(ADR_STATUS, st);
        end
    endtask

    task automatic load_range(input int slot, input longint unsigned lo, input longint unsigned hi);
        wb_write(wb_adr_t'(ADR_LO_BASE + slot), wb_dat_t'(to_bcd(lo)));
        wb_write(wb_adr_t'(ADR_HI_BASE + slot), wb_dat_t'(to_bcd(hi)));
    endtask

    task automatic run_table();
        wb_dat_t rd;
        wb_write(ADR_CTRL, 64'd1);
        wait_done();
        wb_read(ADR_RESULT, rd);   // checker compares
    endtask

    task automatic run_single(input longint unsigned lo, input longint unsigned hi);
        load_range(0, lo, hi);
        wb_write(ADR_COUNT, 64'd1);
        run_table();
    endtask

    initial begin
        longint unsigned lo;
        longint unsigned hi;
        longint unsigned base;
        int              len;
        wb_dat_t         rd;

        clk   = 1'b0;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        void'($urandom(68224));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        wb_read(ADR_STATUS, rd);   // reset values
        wb_read(ADR_COUNT, rd);
        wb_read(ADR_RESULT, rd);

        run_single(64'd11, 64'd22);
        run_single(64'd1188511880, 64'd1188511890);
        run_single(64'd222220, 64'd222224);   // period 1 subtracted

        run_single(64'd95, 64'd115);          // crosses digit lengths
        run_single(64'd998, 64'd1012);
        run_single(64'd5, 64'd2345);

        // ##################################################
        // full random table
        // ##################################################
        for (int i = 0; i < MAX_RANGES; i++) begin
            len  = (i % MAX_DIGITS) + 1;
            base = pow10(len - 1);
            lo   = base + ({$urandom, $urandom} % (9 * base));
            hi   = lo + $urandom_range(4000);
            if (hi > MAX_VALUE) begin
                hi = MAX_VALUE;
            end
            load_range(i, lo, hi);
        end
        wb_write(ADR_COUNT, wb_dat_t'(MAX_RANGES));
        run_table();

        // rerun with an extra start and writes landing while busy
        wb_write(ADR_CTRL, 64'd1);
        wb_write(ADR_CTRL, 64'd1);
        wb_write(ADR_COUNT, 64'd3);
        wb_write(wb_adr_t'(ADR_HI_BASE + 15), wb_dat_t'(to_bcd(1)));
        wait_done();
        wb_read(ADR_RESULT, rd);
        wb_read(ADR_COUNT, rd);

        wb_write(ADR_COUNT, 64'd0);   // empty table
        run_table();

        chk.report_counts();
        if (chk.errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
src/gift_pkg.sv
src/wb_pkg.sv
src/range_table_if.sv
src/period_job_if.sv
src/wb_range_regs.sv
src/range_sequencer.sv
src/period_sum_unit.sv
src/gift_shop_top.sv
verif/gift_checker.sv
verif/tb_gift_shop.sv

// File: Bender.yml
package:
  name: gift_shop

sources:
  - src/gift_pkg.sv
  - src/wb_pkg.sv
  - src/range_table_if.sv
  - src/period_job_if.sv
  - src/wb_range_regs.sv
  - src/range_sequencer.sv
  - src/period_sum_unit.sv
  - src/gift_shop_top.sv

  - target: test
    files:
      - verif/gift_checker.sv
      - verif/tb_gift_shop.sv
